// ==== Bender.yml ====
package:
  name: rotary_input

sources:
  - include_dirs:
      - design
    files:
      - design/rotary_pkg.sv
      - design/input_debouncer.sv
      - design/quadrature_decoder.sv
      - design/position_counter.sv
      - design/rotary_input_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/rotary_input_props.sv
      - dv/rotary_input_tb.sv

// ==== design/input_debouncer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rotary_params.svh"

module input_debouncer #(
	parameter int DEBOUNCE_CYCLES = `ROT_DEBOUNCE_CYCLES
) (
	input  logic clk,
	input  logic rst_n,
	input  logic enc_a,
	input  logic enc_b,
	input  logic enc_sw,
	output logic deb_a,
	output logic deb_b,
	output logic deb_sw
);

	// Number of raw lines handled here
	localparam int NUM_LINES = 3;

	// The counter only ever reaches DEBOUNCE_CYCLES - 1, so that many values need bits
	localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	// Lines packed so one generate loop covers all of them
	// Bit 0 is A, bit 1 is B and bit 2 is the switch
	logic [NUM_LINES-1:0] raw_vec;
	logic [NUM_LINES-1:0] deb_vec;

	assign raw_vec = {enc_sw, enc_b, enc_a};

	////////////////////////////////////////////////////////////
	// Per-line synchronizer and stability filter
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
		// Two-flop synchronizer, the raw pins are fully asynchronous
		logic [1:0] sync_q;

		// Released is high because of the external pull-ups
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				sync_q <= 2'b11;
			end else begin
				sync_q <= {sync_q[0], raw_vec[i]};
			end
		end

		if (DEBOUNCE_CYCLES == 0) begin : g_bypass
			// No filtering requested, pass the synchronized level straight on
			assign deb_vec[i] = sync_q[1];
		end else begin : g_filter
			// Count value at which the mismatch has lasted the full window
			localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

			logic [CNT_W-1:0] cnt_q;
			logic             state_q;
			logic             mismatch;

			// The synchronized level disagrees with what is currently presented
			assign mismatch = sync_q[1] ^ state_q;

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					cnt_q   <= '0;
					state_q <= 1'b1;
				end else if (!mismatch) begin
					// Any agreeing cycle throws away the partial window
					cnt_q <= '0;
				end else if (cnt_q == CNT_LAST) begin
					// Disagreement held for DEBOUNCE_CYCLES cycles so accept it
					state_q <= sync_q[1];
					cnt_q   <= '0;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end

			assign deb_vec[i] = state_q;
		end
	end

	// Still active low on the way out
	assign deb_a  = deb_vec[0];
	assign deb_b  = deb_vec[1];
	assign deb_sw = deb_vec[2];

endmodule

`default_nettype wire

// ==== design/position_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module position_counter import rotary_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     step_valid,
	input  rot_dir_e step_dir,
	input  logic     press,
	input  logic     wrap_en,
	output rot_pos_t position,
	output logic     at_limit
);

	// Current position sits on a limit
	logic at_max;
	logic at_min;

	// Neighbouring values of the current position
	rot_pos_t pos_inc;
	rot_pos_t pos_dec;

	// Value to be loaded on the coming edge
	rot_pos_t pos_next;

	// Limit flag belonging to pos_next
	logic at_limit_next;

	assign at_max  = (position >= POS_MAX);
	assign at_min  = (position <= POS_MIN);
	assign pos_inc = position + POS_STEP;
	assign pos_dec = position - POS_STEP;

	////////////////////////////////////////////////////////////
	// Next position
	////////////////////////////////////////////////////////////

	always_comb begin
		pos_next = position;
		if (press) begin
			// A press wins over any step arriving in the same cycle
			pos_next = '0;
		end else if (step_valid) begin
			if (step_dir == DIR_CW) begin
				if (!at_max) begin
					pos_next = pos_inc;
				end else if (wrap_en) begin
					// Past the top we come around at the bottom
					pos_next = POS_MIN;
				end else begin
					pos_next = POS_MAX;
				end
			end else begin
				if (!at_min) begin
					pos_next = pos_dec;
				end else if (wrap_en) begin
					pos_next = POS_MAX;
				end else begin
					// Saturate at the bottom
					pos_next = POS_MIN;
				end
			end
		end
	end

	// Flag derived from the next value so it lines up with the registered position
	assign at_limit_next = (pos_next == POS_MAX) || (pos_next == POS_MIN);

	////////////////////////////////////////////////////////////
	// Position and limit registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			position <= '0;
			at_limit <= 1'b0;
		end else begin
			position <= pos_next;
			at_limit <= at_limit_next;
		end
	end

endmodule

`default_nettype wire

// ==== design/quadrature_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module quadrature_decoder import rotary_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     deb_a,
	input  logic     deb_b,
	input  logic     deb_sw,
	output logic     step_valid,
	output rot_dir_e step_dir,
	output logic     press
);

	// Active-high views of the debounced lines
	logic act_a;
	logic act_b;

	// Both lines released, which is the detent rest position
	logic marker;

	// Detent marker seen on the previous cycle
	logic marker_q;

	// Previous switch level, high when released
	logic sw_q;

	// One line left the detent on its own this cycle
	logic depart;

	assign act_a  = ~deb_a;
	assign act_b  = ~deb_b;
	assign marker = ~(act_a | act_b);

	// Both lines going active together gives no usable direction and is dropped
	assign depart = marker_q & (act_a ^ act_b);

	////////////////////////////////////////////////////////////
	// Step and press strobes
	////////////////////////////////////////////////////////////

	// Marker starts cleared so a line held active through reset yields no step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			marker_q   <= 1'b0;
			sw_q       <= 1'b1;
			step_valid <= 1'b0;
			press      <= 1'b0;
		end else begin
			marker_q   <= marker;
			sw_q       <= deb_sw;
			// Marker drops on the same edge, so the strobe lasts exactly one cycle
			step_valid <= depart;
			// Released to active transition of the switch
			press      <= sw_q & ~deb_sw;
		end
	end

	// The leading line sets the direction, only meaningful alongside step_valid
	always_ff @(posedge clk) begin
		if (depart) begin
			step_dir <= act_a ? DIR_CW : DIR_CCW;
		end
	end

endmodule

`default_nettype wire

// ==== design/rotary_input_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rotary_input_top import rotary_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     enc_a,
	input  logic     enc_b,
	input  logic     enc_sw,
	input  logic     wrap_en,
	output logic     step_valid,
	output rot_dir_e step_dir,
	output logic     press,
	output rot_pos_t position,
	output logic     at_limit
);

	// Debounced lines, still active low
	logic deb_a;
	logic deb_b;
	logic deb_sw;

	////////////////////////////////////////////////////////////
	// Stage 1, synchronize and debounce
	////////////////////////////////////////////////////////////

	input_debouncer u_input_debouncer (
		.clk    (clk),
		.rst_n  (rst_n),
		.enc_a  (enc_a),
		.enc_b  (enc_b),
		.enc_sw (enc_sw),
		.deb_a  (deb_a),
		.deb_b  (deb_b),
		.deb_sw (deb_sw)
	);

	// Stage 2 turns detent departures into steps and switch edges into presses
	quadrature_decoder u_quadrature_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.deb_a      (deb_a),
		.deb_b      (deb_b),
		.deb_sw     (deb_sw),
		.step_valid (step_valid),
		.step_dir   (step_dir),
		.press      (press)
	);

	// Stage 3 keeps the position, strobes are also visible on the top outputs
	position_counter u_position_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.step_valid (step_valid),
		.step_dir   (step_dir),
		.press      (press),
		.wrap_en    (wrap_en),
		.position   (position),
		.at_limit   (at_limit)
	);

endmodule

`default_nettype wire

// ==== design/rotary_params.svh ====
`ifndef ROTARY_PARAMS_SVH
`define ROTARY_PARAMS_SVH

////////////////////////////////////////////////////////////
// Rotary encoder input defaults
////////////////////////////////////////////////////////////

// Consecutive stable samples needed before a debounced line follows its input
// A value of zero leaves only the two-flop synchronizer in the path
`define ROT_DEBOUNCE_CYCLES 4

// Bit width of the signed position word
`define ROT_POS_WIDTH 8

// Position limits, both inclusive and both within the signed range of the width
`define ROT_POS_MIN (-20)
`define ROT_POS_MAX 20

`endif

// ==== design/rotary_pkg.sv ====
`default_nettype none

`include "rotary_params.svh"

package rotary_pkg;

	////////////////////////////////////////////////////////////
	// Step direction and position types
	////////////////////////////////////////////////////////////

	// Direction of a single detent step
	// Line A leading is clockwise and line B leading is counter-clockwise
	typedef enum logic {
		DIR_CW  = 1'b0,
		DIR_CCW = 1'b1
	} rot_dir_e;

	// Signed position, counts up clockwise and down counter-clockwise
	typedef logic signed [`ROT_POS_WIDTH-1:0] rot_pos_t;

	// Limits cast to the position type so comparisons stay signed
	localparam rot_pos_t POS_MIN = rot_pos_t'(`ROT_POS_MIN);
	localparam rot_pos_t POS_MAX = rot_pos_t'(`ROT_POS_MAX);

	// Single step size in the position type
	localparam rot_pos_t POS_STEP = rot_pos_t'(1);

endpackage

`default_nettype wire

// ==== dv/rotary_input_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module rotary_input_props import rotary_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     step_valid,
	input logic     press,
	input rot_pos_t position,
	input logic     at_limit
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// Strobe width
	////////////////////////////////////////////////////////////

	a_step_single: assert property (@(posedge clk) disable iff (!rst_n)
		step_valid |=> !step_valid)
		else begin
			fail_count++;
			$error("step_valid stayed high for two cycles");
		end

	a_press_single: assert property (@(posedge clk) disable iff (!rst_n)
		press |=> !press)
		else begin
			fail_count++;
			$error("press stayed high for two cycles");
		end

	// Position range and the flag that goes with it
	a_pos_range: assert property (@(posedge clk) disable iff (!rst_n)
		(position >= POS_MIN) && (position <= POS_MAX))
		else begin
			fail_count++;
			$error("position left the limit range");
		end

	a_limit_flag: assert property (@(posedge clk) disable iff (!rst_n)
		at_limit == ((position == POS_MIN) || (position == POS_MAX)))
		else begin
			fail_count++;
			$error("at_limit does not match position");
		end

endmodule

bind rotary_input_top rotary_input_props u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.step_valid (step_valid),
	.press      (press),
	.position   (position),
	.at_limit   (at_limit)
);

`default_nettype wire

// ==== dv/rotary_input_stimulus.txt ====
# Columns: command count bounce expected_position
# R clockwise detents, L counter-clockwise detents, P presses, W wrap_en level in count
R 1 0 1
R 2 0 3
L 1 0 2
L 4 0 -2
R 3 1 1
L 2 1 -1
P 1 0 0
R 22 0 20
R 1 1 20
P 1 1 0
L 20 0 -20
L 2 0 -20
W 1 0 -20
L 1 0 20
R 1 0 -20
R 1 1 -19
L 2 1 20
R 1 0 -20
W 0 0 -20
R 2 0 -18
L 3 0 -20
P 2 1 0
R 5 1 5
L 1 1 4
P 1 0 0

// ==== dv/rotary_input_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rotary_params.svh"

module rotary_input_tb import rotary_pkg::*; ();

	// Timing in clock cycles, every phase sits well past the debounce window
	localparam int DEB      = `ROT_DEBOUNCE_CYCLES;
	localparam int HOLD     = 3 * DEB + 8;
	localparam int WAIT_MAX = 2 * HOLD;
	localparam int LIM_MIN  = `ROT_POS_MIN;
	localparam int LIM_MAX  = `ROT_POS_MAX;

	logic     clk;
	logic     rst_n;
	logic     enc_a;
	logic     enc_b;
	logic     enc_sw;
	logic     wrap_en;
	logic     step_valid;
	rot_dir_e step_dir;
	logic     press;
	rot_pos_t position;
	logic     at_limit;

	int errors;
	int checks;
	int seed;
	int step_seen;
	int press_seen;
	// Expected position, stepped by the counting rules
	int model_pos;

	rotary_input_top dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.enc_a      (enc_a),
		.enc_b      (enc_b),
		.enc_sw     (enc_sw),
		.wrap_en    (wrap_en),
		.step_valid (step_valid),
		.step_dir   (step_dir),
		.press      (press),
		.position   (position),
		.at_limit   (at_limit)
	);

	always #50 clk = ~clk;

	// Strobes are counted on the falling edge where they are stable
	always @(negedge clk) begin
		if (rst_n) begin
			if (step_valid) begin
				step_seen++;
			end
			if (press) begin
				press_seen++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task check_value(input int actual, input int expected, input string what);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	// Advance n cycles and land just after the rising edge
	task tick(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
		end
	endtask

	// Line 0 is A, line 1 is B and anything else is the switch
	task drive_line(input int which, input logic val);
		case (which)
			0: enc_a = val;
			1: enc_b = val;
			default: enc_sw = val;
		endcase
	endtask

	// Glitches before the real edge are all shorter than the debounce window
	task bouncy_edge(input int which, input logic val, input bit bounce);
		int width;
		int k;
		tick(1);
		if (bounce && DEB > 1) begin
			for (k = 0; k < 3; k++) begin
				width = 1 + ($unsigned($random(seed)) % (DEB - 1));
				drive_line(which, val);
				tick(width);
				width = 1 + ($unsigned($random(seed)) % (DEB - 1));
				drive_line(which, !val);
				tick(width);
			end
		end
		drive_line(which, val);
	endtask

	task wait_strobe(input bit want_press, output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < WAIT_MAX && !seen; n++) begin
			@(negedge clk);
			seen = want_press ? press : step_valid;
		end
		if (!seen) begin
			errors++;
			$display("Timeout: no %s strobe arrived within %0d cycles at %0t ns",
				want_press ? "press" : "step", WAIT_MAX, $time);
		end
	endtask

	// Up clockwise and down counter-clockwise, then hold or wrap at a limit
	function int model_step(input int pos, input bit cw, input bit wrap);
		if (cw) begin
			if (pos < LIM_MAX) return pos + 1;
			return wrap ? LIM_MIN : LIM_MAX;
		end
		if (pos > LIM_MIN) return pos - 1;
		return wrap ? LIM_MAX : LIM_MIN;
	endfunction

	// One full detent, the leading line goes first and releases first
	task turn_detent(input bit cw, input bit bounce);
		int lead;
		int trail;
		bit seen;
		lead  = cw ? 0 : 1;
		trail = cw ? 1 : 0;
		bouncy_edge(lead, 1'b0, bounce);
		wait_strobe(1'b0, seen);
		if (seen) begin
			check_value(int'(step_dir), cw ? int'(DIR_CW) : int'(DIR_CCW), "step_dir");
			model_pos = model_step(model_pos, cw, wrap_en);
			@(negedge clk);
			check_value(int'(position), model_pos, "position after step");
		end
		tick(HOLD);
		bouncy_edge(trail, 1'b0, bounce);
		tick(HOLD);
		bouncy_edge(lead, 1'b1, bounce);
		tick(HOLD);
		bouncy_edge(trail, 1'b1, bounce);
		tick(HOLD);
	endtask

	task push_switch(input bit bounce);
		bit seen;
		bouncy_edge(2, 1'b0, bounce);
		wait_strobe(1'b1, seen);
		if (seen) begin
			model_pos = 0;
			@(negedge clk);
			check_value(int'(position), 0, "position after press");
		end
		tick(HOLD);
		bouncy_edge(2, 1'b1, bounce);
		tick(HOLD);
	endtask

	task run_command(input byte cmd, input int cnt, input int bnc, input int exp_pos);
		int steps0;
		int presses0;
		int k;
		steps0   = step_seen;
		presses0 = press_seen;
		case (cmd)
			"R": for (k = 0; k < cnt; k++) turn_detent(1'b1, bnc != 0);
			"L": for (k = 0; k < cnt; k++) turn_detent(1'b0, bnc != 0);
			"P": for (k = 0; k < cnt; k++) push_switch(bnc != 0);
			"W": begin
				tick(1);
				wrap_en = cnt[0];
				tick(2);
			end
			default: begin
				errors++;
				$display("Unknown command %c in the stimulus file", cmd);
			end
		endcase
		// Exactly one strobe per detent or press, none for anything else
		check_value(step_seen - steps0, (cmd == "R" || cmd == "L") ? cnt : 0, "step count");
		check_value(press_seen - presses0, (cmd == "P") ? cnt : 0, "press count");
		check_value(int'(position), exp_pos, "position after command");
		check_value(int'(at_limit), int'(exp_pos == LIM_MIN || exp_pos == LIM_MAX), "at_limit");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		string line;
		byte   cmd;
		int    cnt;
		int    bnc;
		int    exp_pos;
		int    fd;
		int    n;
		clk        = 1'b0;
		rst_n      = 1'b0;
		enc_a      = 1'b1;
		enc_b      = 1'b1;
		enc_sw     = 1'b1;
		wrap_en    = 1'b0;
		errors     = 0;
		checks     = 0;
		seed       = 12431;
		step_seen  = 0;
		press_seen = 0;
		model_pos  = 0;
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;

		// Released inputs after reset must stay quiet
		tick(HOLD);
		check_value(step_seen, 0, "steps while idle");
		check_value(press_seen, 0, "presses while idle");
		check_value(int'(position), 0, "position after reset");
		check_value(int'(at_limit), 0, "at_limit after reset");

		fd = $fopen("dv/rotary_input_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file dv/rotary_input_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Comment and blank lines give fewer than four fields
				n = $sscanf(line, " %c %d %d %d", cmd, cnt, bnc, exp_pos);
				if (n == 4 && cmd != "#") begin
					run_command(cmd, cnt, bnc, exp_pos);
				end
			end
			$fclose(fd);
		end

		// Bound assertion failures count as errors too
		errors += dut0.u_props.fail_count;

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/rotary_pkg.sv
design/input_debouncer.sv
design/quadrature_decoder.sv
design/position_counter.sv
design/rotary_input_top.sv
dv/rotary_input_props.sv
dv/rotary_input_tb.sv
